// File: logic/udp_echo_config.svh
`ifndef UDP_ECHO_CONFIG_SVH
`define UDP_ECHO_CONFIG_SVH

// destination port that gets echoed back
`define ECHO_PORT 16'd1234

// payload beat geometry
`define DATA_W 64
`define KEEP_W 8

// payload buffer entries, power of two
`define FIFO_DEPTH 16

// leds driven from first reply byte
`define LED_W 2

`endif

// File: logic/udp_echo_pkg.sv
`include "udp_echo_config.svh"

package udp_echo_pkg;

    // ipv4 address
    typedef logic [31:0] ip_addr_t;

    // udp header fields
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;

    // one payload beat and its byte enables
    typedef logic [`DATA_W-1:0] payload_data_t;
    typedef logic [`KEEP_W-1:0] payload_keep_t;

    // receive side frame handling
    typedef enum logic [1:0] {
        IDLE,
        FORWARD,
        DROP
    } filter_state_t;

endpackage

// File: logic/udp_echo_top.sv
`timescale 1ns/1ps
`include "udp_echo_config.svh"

module udp_echo_top import udp_echo_pkg::*; (
    input  logic              clk,
    input  logic              rst,

    // received udp frame
    input  logic              rx_hdr_valid,
    output logic              rx_hdr_ready,
    input  ip_addr_t          rx_ip_source_ip,
    input  udp_port_t         rx_source_port,
    input  udp_port_t         rx_dest_port,
    input  udp_len_t          rx_udp_length,
    input  payload_data_t     rx_payload_tdata,
    input  payload_keep_t     rx_payload_tkeep,
    input  logic              rx_payload_tvalid,
    output logic              rx_payload_tready,
    input  logic              rx_payload_tlast,

    // echoed udp frame
    output logic              tx_hdr_valid,
    input  logic              tx_hdr_ready,
    output ip_addr_t          tx_ip_dest_ip,
    output udp_port_t         tx_source_port,
    output udp_port_t         tx_dest_port,
    output udp_len_t          tx_udp_length,
    output payload_data_t     tx_payload_tdata,
    output payload_keep_t     tx_payload_tkeep,
    output logic              tx_payload_tvalid,
    input  logic              tx_payload_tready,
    output logic              tx_payload_tlast,

    output logic [`LED_W-1:0] led
);

    // filter to reply stage
    logic          new_hdr_valid;
    logic          new_hdr_ready;
    ip_addr_t      new_dest_ip;
    udp_port_t     new_source_port;
    udp_port_t     new_dest_port;
    udp_len_t      new_length;

    // filter to payload buffer
    payload_data_t fifo_in_tdata;
    payload_keep_t fifo_in_tkeep;
    logic          fifo_in_tvalid;
    logic          fifo_in_tready;
    logic          fifo_in_tlast;

    udp_port_filter u_filter (
        .clk               (clk),
        .rst               (rst),
        .rx_hdr_valid      (rx_hdr_valid),
        .rx_hdr_ready      (rx_hdr_ready),
        .rx_ip_source_ip   (rx_ip_source_ip),
        .rx_source_port    (rx_source_port),
        .rx_dest_port      (rx_dest_port),
        .rx_udp_length     (rx_udp_length),
        .rx_payload_tdata  (rx_payload_tdata),
        .rx_payload_tkeep  (rx_payload_tkeep),
        .rx_payload_tvalid (rx_payload_tvalid),
        .rx_payload_tready (rx_payload_tready),
        .rx_payload_tlast  (rx_payload_tlast),
        .new_hdr_valid     (new_hdr_valid),
        .new_hdr_ready     (new_hdr_ready),
        .new_dest_ip       (new_dest_ip),
        .new_source_port   (new_source_port),
        .new_dest_port     (new_dest_port),
        .new_length        (new_length),
        .fifo_in_tdata     (fifo_in_tdata),
        .fifo_in_tkeep     (fifo_in_tkeep),
        .fifo_in_tvalid    (fifo_in_tvalid),
        .fifo_in_tready    (fifo_in_tready),
        .fifo_in_tlast     (fifo_in_tlast)
    );

    udp_payload_fifo u_fifo (
        .clk               (clk),
        .rst               (rst),
        .fifo_in_tdata     (fifo_in_tdata),
        .fifo_in_tkeep     (fifo_in_tkeep),
        .fifo_in_tvalid    (fifo_in_tvalid),
        .fifo_in_tready    (fifo_in_tready),
        .fifo_in_tlast     (fifo_in_tlast),
        .tx_payload_tdata  (tx_payload_tdata),
        .tx_payload_tkeep  (tx_payload_tkeep),
        .tx_payload_tvalid (tx_payload_tvalid),
        .tx_payload_tready (tx_payload_tready),
        .tx_payload_tlast  (tx_payload_tlast)
    );

    // watches the outgoing payload for the led byte
    udp_reply_stage u_reply (
        .clk               (clk),
        .rst               (rst),
        .new_hdr_valid     (new_hdr_valid),
        .new_hdr_ready     (new_hdr_ready),
        .new_dest_ip       (new_dest_ip),
        .new_source_port   (new_source_port),
        .new_dest_port     (new_dest_port),
        .new_length        (new_length),
        .tx_hdr_valid      (tx_hdr_valid),
        .tx_hdr_ready      (tx_hdr_ready),
        .tx_ip_dest_ip     (tx_ip_dest_ip),
        .tx_source_port    (tx_source_port),
        .tx_dest_port      (tx_dest_port),
        .tx_udp_length     (tx_udp_length),
        .tx_payload_tdata  (tx_payload_tdata),
        .tx_payload_tvalid (tx_payload_tvalid),
        .tx_payload_tready (tx_payload_tready),
        .tx_payload_tlast  (tx_payload_tlast),
        .led               (led)
    );

endmodule

// File: logic/udp_payload_fifo.sv
`timescale 1ns/1ps
`include "udp_echo_config.svh"

module udp_payload_fifo import udp_echo_pkg::*; (
    input  logic          clk,
    input  logic          rst,

    input  payload_data_t fifo_in_tdata,
    input  payload_keep_t fifo_in_tkeep,
    input  logic          fifo_in_tvalid,
    output logic          fifo_in_tready,
    input  logic          fifo_in_tlast,

    output payload_data_t tx_payload_tdata,
    output payload_keep_t tx_payload_tkeep,
    output logic          tx_payload_tvalid,
    input  logic          tx_payload_tready,
    output logic          tx_payload_tlast
);

    localparam int ADDR_W = $clog2(`FIFO_DEPTH);

    payload_data_t     mem_data [`FIFO_DEPTH];
    payload_keep_t     mem_keep [`FIFO_DEPTH];
    logic              mem_last [`FIFO_DEPTH];

    // extra msb tells full from empty
    logic [ADDR_W:0]   wr_ptr;
    logic [ADDR_W:0]   rd_ptr;
    logic              full;
    logic              empty;
    logic              wr_en;
    logic              rd_en;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                   (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    assign fifo_in_tready = !full;
    assign wr_en = fifo_in_tvalid && !full;

    // refill output register when it is empty or being drained
    assign rd_en = !empty && (!tx_payload_tvalid || tx_payload_tready);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_data[wr_ptr[ADDR_W-1:0]] <= fifo_in_tdata;
            mem_keep[wr_ptr[ADDR_W-1:0]] <= fifo_in_tkeep;
            mem_last[wr_ptr[ADDR_W-1:0]] <= fifo_in_tlast;
        end
        if (rd_en) begin
            tx_payload_tdata <= mem_data[rd_ptr[ADDR_W-1:0]];
            tx_payload_tkeep <= mem_keep[rd_ptr[ADDR_W-1:0]];
            tx_payload_tlast <= mem_last[rd_ptr[ADDR_W-1:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr            <= '0;
            rd_ptr            <= '0;
            tx_payload_tvalid <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr            <= rd_ptr + 1'b1;
                tx_payload_tvalid <= 1'b1;
            end else if (tx_payload_tready) begin
                tx_payload_tvalid <= 1'b0;
            end
        end
    end

    // write pointer must hold while full
    a_no_write_when_full: assert property (
        @(posedge clk) disable iff (rst)
        full |=> (wr_ptr == $past(wr_ptr))
    );

endmodule

// File: logic/udp_port_filter.sv
`timescale 1ns/1ps
`include "udp_echo_config.svh"

module udp_port_filter import udp_echo_pkg::*; (
    input  logic          clk,
    input  logic          rst,

    input  logic          rx_hdr_valid,
    output logic          rx_hdr_ready,
    input  ip_addr_t      rx_ip_source_ip,
    input  udp_port_t     rx_source_port,
    input  udp_port_t     rx_dest_port,
    input  udp_len_t      rx_udp_length,

    input  payload_data_t rx_payload_tdata,
    input  payload_keep_t rx_payload_tkeep,
    input  logic          rx_payload_tvalid,
    output logic          rx_payload_tready,
    input  logic          rx_payload_tlast,

    output logic          new_hdr_valid,
    input  logic          new_hdr_ready,
    output ip_addr_t      new_dest_ip,
    output udp_port_t     new_source_port,
    output udp_port_t     new_dest_port,
    output udp_len_t      new_length,

    output payload_data_t fifo_in_tdata,
    output payload_keep_t fifo_in_tkeep,
    output logic          fifo_in_tvalid,
    input  logic          fifo_in_tready,
    output logic          fifo_in_tlast
);

    filter_state_t state;
    logic          hdr_match;
    logic          hdr_xfer;
    logic          last_xfer;

    assign hdr_match = (rx_dest_port == `ECHO_PORT);

    // a matching header only goes once the reply stage can take it
    assign rx_hdr_ready  = (state == IDLE) && (!hdr_match || new_hdr_ready);
    assign new_hdr_valid = (state == IDLE) && rx_hdr_valid && hdr_match;
    assign hdr_xfer      = rx_hdr_valid && rx_hdr_ready;

    // reply goes back where it came from with ports swapped
    assign new_dest_ip     = rx_ip_source_ip;
    assign new_source_port = rx_dest_port;
    assign new_dest_port   = rx_source_port;
    assign new_length      = rx_udp_length;

    // payload steering
    assign fifo_in_tdata  = rx_payload_tdata;
    assign fifo_in_tkeep  = rx_payload_tkeep;
    assign fifo_in_tlast  = rx_payload_tlast;
    assign fifo_in_tvalid = rx_payload_tvalid && (state == FORWARD);

    // drop path sinks every beat
    assign rx_payload_tready = ((state == FORWARD) && fifo_in_tready) || (state == DROP);

    assign last_xfer = rx_payload_tvalid && rx_payload_tready && rx_payload_tlast;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (hdr_xfer) begin
                        state <= hdr_match ? FORWARD : DROP;
                    end
                end
                FORWARD, DROP: begin
                    if (last_xfer) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // one frame at a time so payload waits for its header
    a_no_payload_in_idle: assert property (
        @(posedge clk) disable iff (rst)
        (state == IDLE) && !hdr_xfer |=> !rx_payload_tready
    );

endmodule

// File: logic/udp_reply_stage.sv
`timescale 1ns/1ps
`include "udp_echo_config.svh"

module udp_reply_stage import udp_echo_pkg::*; (
    input  logic                clk,
    input  logic                rst,

    input  logic                new_hdr_valid,
    output logic                new_hdr_ready,
    input  ip_addr_t            new_dest_ip,
    input  udp_port_t           new_source_port,
    input  udp_port_t           new_dest_port,
    input  udp_len_t            new_length,

    output logic                tx_hdr_valid,
    input  logic                tx_hdr_ready,
    output ip_addr_t            tx_ip_dest_ip,
    output udp_port_t           tx_source_port,
    output udp_port_t           tx_dest_port,
    output udp_len_t            tx_udp_length,

    input  payload_data_t       tx_payload_tdata,
    input  logic                tx_payload_tvalid,
    input  logic                tx_payload_tready,
    input  logic                tx_payload_tlast,

    output logic [`LED_W-1:0]   led
);

    logic hdr_full;
    logic in_frame;
    logic pay_xfer;

    // single slot header buffer
    assign new_hdr_ready = !hdr_full;
    assign tx_hdr_valid  = hdr_full;

    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_full <= 1'b0;
        end else if (new_hdr_valid && new_hdr_ready) begin
            hdr_full <= 1'b1;
        end else if (tx_hdr_ready) begin
            hdr_full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (new_hdr_valid && new_hdr_ready) begin
            tx_ip_dest_ip  <= new_dest_ip;
            tx_source_port <= new_source_port;
            tx_dest_port   <= new_dest_port;
            tx_udp_length  <= new_length;
        end
    end

    assign pay_xfer = tx_payload_tvalid && tx_payload_tready;

    // first beat of each outgoing frame sets the leds
    always_ff @(posedge clk) begin
        if (rst) begin
            in_frame <= 1'b0;
            led      <= '0;
        end else if (pay_xfer) begin
            if (!in_frame) begin
                led <= tx_payload_tdata[`LED_W-1:0];
            end
            in_frame <= !tx_payload_tlast;
        end
    end

    a_hdr_stable: assert property (
        @(posedge clk) disable iff (rst)
        (tx_hdr_valid && !tx_hdr_ready) |=>
            tx_hdr_valid && $stable(tx_ip_dest_ip) && $stable(tx_source_port) &&
            $stable(tx_dest_port) && $stable(tx_udp_length)
    );

endmodule

// File: sources.f
+incdir+logic
+incdir+verif
logic/udp_echo_pkg.sv
logic/udp_port_filter.sv
logic/udp_payload_fifo.sv
logic/udp_reply_stage.sv
logic/udp_echo_top.sv
verif/udp_echo_tb.sv

// File: verif/udp_echo_tasks.svh
// drives one frame; a frame to the echo port also queues its expected reply
task automatic send_frame(input ip_addr_t ip, input udp_port_t sport, input udp_port_t dport,
                          input int beats, input payload_keep_t last_keep);
    payload_data_t data;
    int            wait_cnt;
    udp_len_t      len;
    len = 16'd8 + 16'(8 * (beats - 1)) + 16'($countones(last_keep));
    @(negedge clk);
    rx_hdr_valid    = 1'b1;
    rx_ip_source_ip = ip;
    rx_source_port  = sport;
    rx_dest_port    = dport;
    rx_udp_length   = len;
    wait_cnt = 0;
    @(posedge clk);
    while (!rx_hdr_ready) begin
        wait_cnt++;
        if (wait_cnt > 200)
            stop_on_error("timeout waiting for rx_hdr_ready");
        @(posedge clk);
    end
    if (dport == `ECHO_PORT) begin
        // reply goes back to the sender with ports swapped
        exp_ip.push_back(ip);
        exp_sport.push_back(dport);
        exp_dport.push_back(sport);
        exp_len.push_back(len);
    end
    for (int i = 0; i < beats; i++) begin
        @(negedge clk);
        rx_hdr_valid      = 1'b0;
        data              = {$random(seed), $random(seed)};
        rx_payload_tvalid = 1'b1;
        rx_payload_tdata  = data;
        rx_payload_tkeep  = (i == beats - 1) ? last_keep : '1;
        rx_payload_tlast  = (i == beats - 1);
        if (dport == `ECHO_PORT) begin
            exp_data.push_back(data);
            exp_keep.push_back(rx_payload_tkeep);
            exp_last.push_back(rx_payload_tlast);
            if (i == 0)
                exp_led = data[`LED_W-1:0];
        end
        wait_cnt = 0;
        @(posedge clk);
        while (!rx_payload_tready) begin
            wait_cnt++;
            if (wait_cnt > 500)
                stop_on_error("timeout waiting for rx_payload_tready");
            @(posedge clk);
        end
    end
    @(negedge clk);
    rx_payload_tvalid = 1'b0;
    rx_payload_tlast  = 1'b0;
endtask

// waits until every expected reply has shown up, then compares in order
task automatic wait_and_check_replies();
    int wait_cnt;
    wait_cnt = 0;
    while (got_ip.size() < exp_ip.size() || got_data.size() < exp_data.size()) begin
        @(negedge clk);
        wait_cnt++;
        if (wait_cnt > 2000)
            stop_on_error("timeout waiting for the echoed frames");
    end
    // quiet window so an extra reply would be counted
    repeat (20) @(negedge clk);
    assert (got_ip.size() == exp_ip.size())
        else stop_on_error($sformatf("[FAIL] tx header count %h expected %h",
                                     got_ip.size(), exp_ip.size()));
    assert (got_data.size() == exp_data.size())
        else stop_on_error($sformatf("[FAIL] tx payload beat count %h expected %h",
                                     got_data.size(), exp_data.size()));
    for (int i = 0; i < exp_ip.size(); i++) begin
        assert (got_ip[i] == exp_ip[i])
            else stop_on_error($sformatf("[FAIL] tx_ip_dest_ip %h expected %h",
                                         got_ip[i], exp_ip[i]));
        assert (got_sport[i] == exp_sport[i])
            else stop_on_error($sformatf("[FAIL] tx_source_port %h expected %h",
                                         got_sport[i], exp_sport[i]));
        assert (got_dport[i] == exp_dport[i])
            else stop_on_error($sformatf("[FAIL] tx_dest_port %h expected %h",
                                         got_dport[i], exp_dport[i]));
        assert (got_len[i] == exp_len[i])
            else stop_on_error($sformatf("[FAIL] tx_udp_length %h expected %h",
                                         got_len[i], exp_len[i]));
    end
    for (int i = 0; i < exp_data.size(); i++) begin
        assert (got_data[i] == exp_data[i])
            else stop_on_error($sformatf("[FAIL] tx_payload_tdata %h expected %h",
                                         got_data[i], exp_data[i]));
        assert (got_keep[i] == exp_keep[i])
            else stop_on_error($sformatf("[FAIL] tx_payload_tkeep %h expected %h",
                                         got_keep[i], exp_keep[i]));
        assert (got_last[i] == exp_last[i])
            else stop_on_error($sformatf("[FAIL] tx_payload_tlast %h expected %h",
                                         got_last[i], exp_last[i]));
    end
    got_ip.delete();
    got_sport.delete();
    got_dport.delete();
    got_len.delete();
    got_data.delete();
    got_keep.delete();
    got_last.delete();
    exp_ip.delete();
    exp_sport.delete();
    exp_dport.delete();
    exp_len.delete();
    exp_data.delete();
    exp_keep.delete();
    exp_last.delete();
endtask

// File: verif/udp_echo_tb.sv
`timescale 1ns/1ps
`include "udp_echo_config.svh"

module udp_echo_tb import udp_echo_pkg::*; ();

    logic              clk;
    logic              rst;
    logic              rx_hdr_valid;
    logic              rx_hdr_ready;
    ip_addr_t          rx_ip_source_ip;
    udp_port_t         rx_source_port;
    udp_port_t         rx_dest_port;
    udp_len_t          rx_udp_length;
    payload_data_t     rx_payload_tdata;
    payload_keep_t     rx_payload_tkeep;
    logic              rx_payload_tvalid;
    logic              rx_payload_tready;
    logic              rx_payload_tlast;
    logic              tx_hdr_valid;
    logic              tx_hdr_ready;
    ip_addr_t          tx_ip_dest_ip;
    udp_port_t         tx_source_port;
    udp_port_t         tx_dest_port;
    udp_len_t          tx_udp_length;
    payload_data_t     tx_payload_tdata;
    payload_keep_t     tx_payload_tkeep;
    logic              tx_payload_tvalid;
    logic              tx_payload_tready;
    logic              tx_payload_tlast;
    logic [`LED_W-1:0] led;

    integer            seed = 79;
    logic              rand_ready;
    logic [`LED_W-1:0] exp_led;

    // observed on the tx side and predicted from what was sent
    ip_addr_t      got_ip[$];
    udp_port_t     got_sport[$];
    udp_port_t     got_dport[$];
    udp_len_t      got_len[$];
    payload_data_t got_data[$];
    payload_keep_t got_keep[$];
    logic          got_last[$];
    ip_addr_t      exp_ip[$];
    udp_port_t     exp_sport[$];
    udp_port_t     exp_dport[$];
    udp_len_t      exp_len[$];
    payload_data_t exp_data[$];
    payload_keep_t exp_keep[$];
    logic          exp_last[$];

    // stall seen last cycle and the fields that must still hold
    logic          hdr_stall;
    logic          pay_stall;
    logic [79:0]   hold_hdr;
    logic [72:0]   hold_pay;

    udp_echo_top UUT (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    `include "udp_echo_tasks.svh"

    // downstream ready goes random during the back-pressure test
    always @(negedge clk) begin
        if (rand_ready) begin
            tx_payload_tready = 1'($random(seed));
            tx_hdr_ready      = 1'($random(seed));
        end else begin
            tx_payload_tready = 1'b1;
            tx_hdr_ready      = 1'b1;
        end
    end

    // tx monitor
    always @(posedge clk) begin
        if (rst) begin
            hdr_stall <= 1'b0;
            pay_stall <= 1'b0;
        end else begin
            if (hdr_stall) begin
                assert (tx_hdr_valid)
                    else stop_on_error("tx_hdr_valid dropped before tx_hdr_ready");
                assert ({tx_ip_dest_ip, tx_source_port, tx_dest_port, tx_udp_length} == hold_hdr)
                    else stop_on_error($sformatf("[FAIL] tx header fields %h expected %h",
                        {tx_ip_dest_ip, tx_source_port, tx_dest_port, tx_udp_length}, hold_hdr));
            end
            if (pay_stall) begin
                assert (tx_payload_tvalid)
                    else stop_on_error("tx_payload_tvalid dropped before tx_payload_tready");
                assert ({tx_payload_tdata, tx_payload_tkeep, tx_payload_tlast} == hold_pay)
                    else stop_on_error($sformatf("[FAIL] tx payload beat %h expected %h",
                        {tx_payload_tdata, tx_payload_tkeep, tx_payload_tlast}, hold_pay));
            end
            hdr_stall <= tx_hdr_valid && !tx_hdr_ready;
            pay_stall <= tx_payload_tvalid && !tx_payload_tready;
            hold_hdr  <= {tx_ip_dest_ip, tx_source_port, tx_dest_port, tx_udp_length};
            hold_pay  <= {tx_payload_tdata, tx_payload_tkeep, tx_payload_tlast};
            if (tx_hdr_valid && tx_hdr_ready) begin
                got_ip.push_back(tx_ip_dest_ip);
                got_sport.push_back(tx_source_port);
                got_dport.push_back(tx_dest_port);
                got_len.push_back(tx_udp_length);
            end
            if (tx_payload_tvalid && tx_payload_tready) begin
                got_data.push_back(tx_payload_tdata);
                got_keep.push_back(tx_payload_tkeep);
                got_last.push_back(tx_payload_tlast);
            end
        end
    end

    task automatic check_reset_state();
        repeat (2) @(negedge clk);
        assert (tx_hdr_valid == 1'b0)
            else stop_on_error($sformatf("[FAIL] tx_hdr_valid %h expected 0", tx_hdr_valid));
        assert (tx_payload_tvalid == 1'b0)
            else stop_on_error($sformatf("[FAIL] tx_payload_tvalid %h expected 0",
                                         tx_payload_tvalid));
        assert (led == '0)
            else stop_on_error($sformatf("[FAIL] led %h expected 0", led));
    endtask

    task automatic echo_single_frame();
        send_frame(32'hC0A8_0105, 16'd5555, `ECHO_PORT, 3, 8'h07);
        wait_and_check_replies();
    endtask

    task automatic drop_other_port();
        send_frame(32'h0A00_0002, 16'd4000, 16'd80, 4, 8'h3F);
        repeat (50) @(negedge clk);
        assert (got_ip.size() == 0)
            else stop_on_error($sformatf("[FAIL] tx header count %h expected 0", got_ip.size()));
        assert (got_data.size() == 0)
            else stop_on_error($sformatf("[FAIL] tx payload beat count %h expected 0",
                                         got_data.size()));
    endtask

    task automatic echo_with_backpressure();
        rand_ready = 1'b1;
        send_frame(32'hAC10_2033, 16'd6001, `ECHO_PORT, 40, 8'h01);
        wait_and_check_replies();
        rand_ready = 1'b0;
    endtask

    task automatic interleave_frames();
        send_frame(32'hC0A8_0A01, 16'd7000, `ECHO_PORT, 2, 8'hFF);
        send_frame(32'hC0A8_0A02, 16'd7001, 16'd53, 3, 8'h0F);
        send_frame(32'hC0A8_0A03, 16'd7002, `ECHO_PORT, 5, 8'h03);
        wait_and_check_replies();
        assert (led == exp_led)
            else stop_on_error($sformatf("[FAIL] led %h expected %h", led, exp_led));
    endtask

    initial begin
        rst               = 1'b1;
        rand_ready        = 1'b0;
        exp_led           = '0;
        rx_hdr_valid      = 1'b0;
        rx_ip_source_ip   = '0;
        rx_source_port    = '0;
        rx_dest_port      = '0;
        rx_udp_length     = '0;
        rx_payload_tdata  = '0;
        rx_payload_tkeep  = '0;
        rx_payload_tvalid = 1'b0;
        rx_payload_tlast  = 1'b0;
        tx_hdr_ready      = 1'b1;
        tx_payload_tready = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_reset_state();
        echo_single_frame();
        drop_other_port();
        echo_with_backpressure();
        interleave_frames();
        $display("PASS: all tests");
        $finish;
    end

endmodule
